// ==== mips_isa_pkg.sv ====
package mips_isa_pkg;

	////////////////////////////////////////
	// instruction word layout
	////////////////////////////////////////

	// field widths
	localparam int op_w     = 6;
	localparam int funct_w  = 6;
	localparam int imm_w    = 16;
	localparam int target_w = 26;

	// lsb of each field inside the 32-bit word
	localparam int op_lsb = 26;
	localparam int rs_lsb = 21;
	localparam int rt_lsb = 16;
	localparam int rd_lsb = 11;

	////////////////////////////////////////
	// encodings
	////////////////////////////////////////

	// primary opcodes, halt sits on the reserved top value
	typedef enum logic [op_w-1:0] {
		op_rtype = 6'h00,
		op_j     = 6'h02,
		op_beq   = 6'h04,
		op_addi  = 6'h08,
		op_lw    = 6'h23,
		op_sw    = 6'h2B,
		op_halt  = 6'h3F
	} opcode_t;

	// r-type function field
	typedef enum logic [funct_w-1:0] {
		fn_add = 6'h20,
		fn_sub = 6'h22,
		fn_and = 6'h24,
		fn_or  = 6'h25,
		fn_slt = 6'h2A
	} funct_t;

endpackage

// ==== mips_ctrl_pkg.sv ====
package mips_ctrl_pkg;

	////////////////////////////////////////
	// datapath shape between stages
	////////////////////////////////////////

	// word width, fixed by the isa
	localparam int data_w = 32;
	// register number width
	localparam int reg_w = 5;

	////////////////////////////////////////
	// alu operation
	////////////////////////////////////////

	// carried id -> ex next to the loose control bits
	//   reg_write   : result goes to the register file
	//   mem_to_reg  : write-back takes the loaded word
	//   mem_read    : lw, also drives load-use detection
	//   mem_write   : sw
	//   branch      : beq, resolved in mem
	//   alu_src_imm : operand b is the sign-extended immediate
	//   reg_dst_rd  : destination is rd, else rt
	typedef enum logic [2:0] {
		alu_add = 3'd0,
		alu_sub = 3'd1,
		alu_and = 3'd2,
		alu_or  = 3'd3,
		alu_slt = 3'd4
	} alu_op_t;

endpackage

// ==== if_id.sv ====
`timescale 1ns/1ps

module if_id import mips_isa_pkg::*; #(
	parameter int len_addr = 8
) (
	input  logic                clk,
	input  logic                arst_n,
	// program load port
	input  logic                debug_flag,
	input  logic [len_addr-1:0] in_addr_mem_inst,
	input  logic [31:0]         in_ins_to_mem,
	input  logic                wea_ram_inst,
	// redirects and hold from later stages
	input  logic                stall,
	input  logic                jump,
	input  logic [31:0]         jump_target,
	input  logic                pc_src,
	input  logic [31:0]         branch_target,
	// IF/ID register
	output logic [31:0]         pc_plus4_d,
	output logic [31:0]         instruction_d,
	output logic                halt_d,
	output logic [7:0]          out_pc
);

	logic [31:0] pc;
	logic [31:0] pc_plus4;
	logic [31:0] fetch_word;
	logic        fetch_halt;
	// a halt was accepted, nothing more is issued
	logic        halted;

	// word-addressed instruction memory
	logic [31:0] imem [2**len_addr];

	////////////////////////////////////////
	// instruction memory
	////////////////////////////////////////

	// load port writes at every enabled edge
	always_ff @(posedge clk) begin
		if (wea_ram_inst)
			imem[in_addr_mem_inst] <= in_ins_to_mem;
	end

	// combinational fetch, byte pc to word index
	assign fetch_word = imem[pc[len_addr+1:2]];
	assign fetch_halt = (fetch_word[op_lsb +: op_w] == op_halt);
	assign pc_plus4   = pc + 32'd4;
	assign out_pc     = pc[7:0];

	////////////////////////////////////////
	// program counter
	////////////////////////////////////////

	// branch from mem beats everything, then hold, then jump
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n)
			pc <= '0;
		else if (debug_flag)
			pc <= '0;
		else if (pc_src)
			pc <= branch_target;
		else if (stall || halted)
			pc <= pc;
		else if (jump)
			pc <= jump_target;
		else if (!fetch_halt)
			pc <= pc_plus4;
	end

	////////////////////////////////////////
	// IF/ID register
	////////////////////////////////////////

	// all-zero word decodes as a no-op
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			pc_plus4_d    <= '0;
			instruction_d <= '0;
			halt_d        <= 1'b0;
			halted        <= 1'b0;
		end else if (debug_flag) begin
			pc_plus4_d    <= '0;
			instruction_d <= '0;
			halt_d        <= 1'b0;
			halted        <= 1'b0;
		end else if (pc_src) begin
			// taken beq, older halt never happened
			instruction_d <= '0;
			halt_d        <= 1'b0;
			halted        <= 1'b0;
		end else if (stall) begin
			instruction_d <= instruction_d;
		end else if (jump || halted) begin
			// squash the jump slot, or idle after halt
			instruction_d <= '0;
			halt_d        <= 1'b0;
		end else begin
			pc_plus4_d    <= pc_plus4;
			instruction_d <= fetch_word;
			halt_d        <= fetch_halt;
			halted        <= fetch_halt;
		end
	end

endmodule

// ==== id_ex.sv ====
`timescale 1ns/1ps

module id_ex import mips_isa_pkg::*, mips_ctrl_pkg::*; (
	input  logic              clk,
	input  logic              arst_n,
	input  logic              debug_flag,
	// from IF/ID
	input  logic [data_w-1:0] pc_plus4_d,
	input  logic [data_w-1:0] instruction_d,
	input  logic              halt_d,
	// taken branch in mem
	input  logic              flush,
	// register file write from write-back
	input  logic              wb_reg_write,
	input  logic [reg_w-1:0]  wb_reg,
	input  logic [data_w-1:0] wb_data,
	// debug read
	input  logic [reg_w-1:0]  dbg_reg_addr,
	output logic [data_w-1:0] dbg_reg_data,
	// to fetch
	output logic              stall,
	output logic              jump,
	output logic [data_w-1:0] jump_target,
	// ID/EX register
	output logic [data_w-1:0] pc_plus4_e,
	output logic [data_w-1:0] reg1_e,
	output logic [data_w-1:0] reg2_e,
	output logic [data_w-1:0] imm_e,
	output logic [reg_w-1:0]  rs_e,
	output logic [reg_w-1:0]  rt_e,
	output logic [reg_w-1:0]  rd_e,
	output logic              reg_write_e,
	output logic              mem_to_reg_e,
	output logic              mem_read_e,
	output logic              mem_write_e,
	output logic              branch_e,
	output logic              alu_src_imm_e,
	output logic              reg_dst_rd_e,
	output alu_op_t           alu_op_e,
	output logic              halt_e
);

	opcode_t           opcode;
	funct_t            funct;
	logic [reg_w-1:0]  rs_d;
	logic [reg_w-1:0]  rt_d;
	logic [reg_w-1:0]  rd_d;
	logic [data_w-1:0] imm_d;
	logic [data_w-1:0] reg1_d;
	logic [data_w-1:0] reg2_d;

	// decoded control
	logic    reg_write_d;
	logic    mem_to_reg_d;
	logic    mem_read_d;
	logic    mem_write_d;
	logic    branch_d;
	logic    alu_src_imm_d;
	logic    reg_dst_rd_d;
	alu_op_t alu_op_d;
	logic    uses_rs;
	logic    uses_rt;
	logic    bubble;

	logic [data_w-1:0] regs [2**reg_w];

	////////////////////////////////////////
	// field split
	////////////////////////////////////////

	assign opcode = opcode_t'(instruction_d[op_lsb +: op_w]);
	assign funct  = funct_t'(instruction_d[funct_w-1:0]);
	assign rs_d   = instruction_d[rs_lsb +: reg_w];
	assign rt_d   = instruction_d[rt_lsb +: reg_w];
	assign rd_d   = instruction_d[rd_lsb +: reg_w];
	// sign extend
	assign imm_d  = {{(data_w-imm_w){instruction_d[imm_w-1]}}, instruction_d[imm_w-1:0]};

	// j keeps the upper nibble of pc+4
	assign jump_target = {pc_plus4_d[data_w-1:data_w-4], instruction_d[target_w-1:0], 2'b00};

	////////////////////////////////////////
	// decoder
	////////////////////////////////////////

	always_comb begin
		reg_write_d   = 1'b0;
		mem_to_reg_d  = 1'b0;
		mem_read_d    = 1'b0;
		mem_write_d   = 1'b0;
		branch_d      = 1'b0;
		alu_src_imm_d = 1'b0;
		reg_dst_rd_d  = 1'b0;
		alu_op_d      = alu_add;
		jump          = 1'b0;
		uses_rs       = 1'b0;
		uses_rt       = 1'b0;
		case (opcode)
			op_rtype: begin
				uses_rs      = 1'b1;
				uses_rt      = 1'b1;
				reg_dst_rd_d = 1'b1;
				reg_write_d  = 1'b1;
				case (funct)
					fn_add: alu_op_d = alu_add;
					fn_sub: alu_op_d = alu_sub;
					fn_and: alu_op_d = alu_and;
					fn_or: alu_op_d = alu_or;
					fn_slt: alu_op_d = alu_slt;
					// the all-zero no-op lands here
					default: reg_write_d = 1'b0;
				endcase
			end
			op_addi: begin
				uses_rs       = 1'b1;
				reg_write_d   = 1'b1;
				alu_src_imm_d = 1'b1;
			end
			op_lw: begin
				uses_rs       = 1'b1;
				reg_write_d   = 1'b1;
				mem_to_reg_d  = 1'b1;
				mem_read_d    = 1'b1;
				alu_src_imm_d = 1'b1;
			end
			op_sw: begin
				uses_rs       = 1'b1;
				uses_rt       = 1'b1;
				mem_write_d   = 1'b1;
				alu_src_imm_d = 1'b1;
			end
			op_beq: begin
				uses_rs  = 1'b1;
				uses_rt  = 1'b1;
				branch_d = 1'b1;
				alu_op_d = alu_sub;
			end
			// resolved right here, fetch redirects next edge
			op_j: jump = 1'b1;
			default: ;
		endcase
	end

	////////////////////////////////////////
	// register file
	////////////////////////////////////////

	// write at the edge, $0 never written
	always_ff @(posedge clk) begin
		if (wb_reg_write && (wb_reg != '0))
			regs[wb_reg] <= wb_data;
	end

	// same-cycle write shows through to the reader
	function automatic logic [data_w-1:0] read_reg(input logic [reg_w-1:0] addr);
		if (addr == '0)
			return '0;
		else if (wb_reg_write && (wb_reg == addr))
			return wb_data;
		else
			return regs[addr];
	endfunction

	always_comb begin
		reg1_d       = read_reg(rs_d);
		reg2_d       = read_reg(rt_d);
		dbg_reg_data = read_reg(dbg_reg_addr);
	end

	////////////////////////////////////////
	// load-use hazard
	////////////////////////////////////////

	// lw in ex writes rt, one bubble is enough
	assign stall = mem_read_e && (rt_e != '0) &&
		((uses_rs && (rt_e == rs_d)) || (uses_rt && (rt_e == rt_d)));

	assign bubble = debug_flag | flush | stall;

	////////////////////////////////////////
	// ID/EX register
	////////////////////////////////////////

	// control side, cleared on a bubble
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			reg_write_e   <= 1'b0;
			mem_to_reg_e  <= 1'b0;
			mem_read_e    <= 1'b0;
			mem_write_e   <= 1'b0;
			branch_e      <= 1'b0;
			alu_src_imm_e <= 1'b0;
			reg_dst_rd_e  <= 1'b0;
			alu_op_e      <= alu_add;
			halt_e        <= 1'b0;
		end else begin
			reg_write_e   <= reg_write_d & ~bubble;
			mem_to_reg_e  <= mem_to_reg_d & ~bubble;
			mem_read_e    <= mem_read_d & ~bubble;
			mem_write_e   <= mem_write_d & ~bubble;
			branch_e      <= branch_d & ~bubble;
			alu_src_imm_e <= alu_src_imm_d & ~bubble;
			reg_dst_rd_e  <= reg_dst_rd_d & ~bubble;
			alu_op_e      <= bubble ? alu_add : alu_op_d;
			halt_e        <= halt_d & ~bubble;
		end
	end

	// data side
	always_ff @(posedge clk) begin
		pc_plus4_e <= pc_plus4_d;
		reg1_e     <= reg1_d;
		reg2_e     <= reg2_d;
		imm_e      <= imm_d;
		rs_e       <= rs_d;
		rt_e       <= rt_d;
		rd_e       <= rd_d;
	end

endmodule

// ==== ex_mem.sv ====
`timescale 1ns/1ps

module ex_mem import mips_ctrl_pkg::*; (
	input  logic              clk,
	input  logic              arst_n,
	input  logic              debug_flag,
	input  logic              flush,
	// ID/EX register
	input  logic [data_w-1:0] pc_plus4_e,
	input  logic [data_w-1:0] reg1_e,
	input  logic [data_w-1:0] reg2_e,
	input  logic [data_w-1:0] imm_e,
	input  logic [reg_w-1:0]  rs_e,
	input  logic [reg_w-1:0]  rt_e,
	input  logic [reg_w-1:0]  rd_e,
	input  logic              reg_write_e,
	input  logic              mem_to_reg_e,
	input  logic              mem_read_e,
	input  logic              mem_write_e,
	input  logic              branch_e,
	input  logic              alu_src_imm_e,
	input  logic              reg_dst_rd_e,
	input  alu_op_t           alu_op_e,
	input  logic              halt_e,
	// write-back, second forwarding source
	input  logic              wb_reg_write,
	input  logic [reg_w-1:0]  wb_reg,
	input  logic [data_w-1:0] wb_data,
	// EX/MEM register
	output logic [data_w-1:0] alu_m,
	output logic [data_w-1:0] store_data_m,
	output logic [reg_w-1:0]  write_reg_m,
	output logic [data_w-1:0] branch_target_m,
	output logic              zero_m,
	output logic              mem_read_m,
	output logic              mem_write_m,
	output logic              branch_m,
	output logic              reg_write_m,
	output logic              mem_to_reg_m,
	output logic              halt_m
);

	logic [data_w-1:0] op_a;
	logic [data_w-1:0] fwd_b;
	logic [data_w-1:0] op_b;
	logic [data_w-1:0] alu_res;
	logic [reg_w-1:0]  write_reg;
	logic              kill;

	////////////////////////////////////////
	// forwarding
	////////////////////////////////////////

	// younger result in EX/MEM wins over write-back
	function automatic logic [data_w-1:0] fwd(
		input logic [reg_w-1:0]  src,
		input logic [data_w-1:0] id_val
	);
		if (reg_write_m && (write_reg_m != '0) && (write_reg_m == src))
			return alu_m;
		else if (wb_reg_write && (wb_reg != '0) && (wb_reg == src))
			return wb_data;
		else
			return id_val;
	endfunction

	always_comb begin
		op_a  = fwd(rs_e, reg1_e);
		fwd_b = fwd(rt_e, reg2_e);
		op_b  = alu_src_imm_e ? imm_e : fwd_b;
	end

	////////////////////////////////////////
	// alu
	////////////////////////////////////////

	always_comb begin
		case (alu_op_e)
			alu_add: alu_res = op_a + op_b;
			alu_sub: alu_res = op_a - op_b;
			alu_and: alu_res = op_a & op_b;
			alu_or: alu_res = op_a | op_b;
			alu_slt: alu_res = {{(data_w-1){1'b0}}, $signed(op_a) < $signed(op_b)};
			default: alu_res = op_a + op_b;
		endcase
	end

	// rd for r-type, rt for addi and lw
	assign write_reg = reg_dst_rd_e ? rd_e : rt_e;
	assign kill      = debug_flag | flush;

	////////////////////////////////////////
	// EX/MEM register
	////////////////////////////////////////

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			mem_read_m   <= 1'b0;
			mem_write_m  <= 1'b0;
			branch_m     <= 1'b0;
			reg_write_m  <= 1'b0;
			mem_to_reg_m <= 1'b0;
			halt_m       <= 1'b0;
		end else begin
			mem_read_m   <= mem_read_e & ~kill;
			mem_write_m  <= mem_write_e & ~kill;
			branch_m     <= branch_e & ~kill;
			reg_write_m  <= reg_write_e & ~kill;
			mem_to_reg_m <= mem_to_reg_e & ~kill;
			halt_m       <= halt_e & ~kill;
		end
	end

	// beq target is pc+4 plus the word offset
	always_ff @(posedge clk) begin
		alu_m           <= alu_res;
		store_data_m    <= fwd_b;
		write_reg_m     <= write_reg;
		branch_target_m <= pc_plus4_e + {imm_e[data_w-3:0], 2'b00};
		zero_m          <= (alu_res == '0);
	end

endmodule

// ==== mem_wb.sv ====
`timescale 1ns/1ps

module mem_wb import mips_ctrl_pkg::*; #(
	parameter int len_dmem_addr = 6
) (
	input  logic              clk,
	input  logic              arst_n,
	input  logic              debug_flag,
	// EX/MEM register
	input  logic [data_w-1:0] alu_m,
	input  logic [data_w-1:0] store_data_m,
	input  logic [reg_w-1:0]  write_reg_m,
	input  logic [data_w-1:0] branch_target_m,
	input  logic              zero_m,
	input  logic              mem_read_m,
	input  logic              mem_write_m,
	input  logic              branch_m,
	input  logic              reg_write_m,
	input  logic              mem_to_reg_m,
	input  logic              halt_m,
	// branch redirect and flush
	output logic              pc_src,
	output logic [data_w-1:0] branch_target,
	// write-back
	output logic              wb_reg_write,
	output logic [reg_w-1:0]  wb_reg,
	output logic [data_w-1:0] wb_data,
	output logic              halt_w
);

	logic [len_dmem_addr-1:0] dmem_idx;
	logic [data_w-1:0]        rd_word;
	logic                     mem_to_reg_w;
	logic [data_w-1:0]        alu_w;
	logic [data_w-1:0]        load_w;

	logic [data_w-1:0] dmem [2**len_dmem_addr];

	////////////////////////////////////////
	// data memory
	////////////////////////////////////////

	// word access only, byte offset dropped
	assign dmem_idx = alu_m[len_dmem_addr+1:2];
	assign rd_word  = dmem[dmem_idx];

	always_ff @(posedge clk) begin
		if (mem_write_m)
			dmem[dmem_idx] <= store_data_m;
	end

	// beq taken, flushes the three younger stages
	assign pc_src        = branch_m & zero_m;
	assign branch_target = branch_target_m;

	////////////////////////////////////////
	// MEM/WB register
	////////////////////////////////////////

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			wb_reg_write <= 1'b0;
			mem_to_reg_w <= 1'b0;
			halt_w       <= 1'b0;
		end else if (debug_flag) begin
			wb_reg_write <= 1'b0;
			mem_to_reg_w <= 1'b0;
			halt_w       <= 1'b0;
		end else begin
			wb_reg_write <= reg_write_m;
			mem_to_reg_w <= mem_to_reg_m;
			// sticky once halt arrives
			if (halt_m)
				halt_w <= 1'b1;
		end
	end

	always_ff @(posedge clk) begin
		wb_reg <= write_reg_m;
		alu_w  <= alu_m;
		if (mem_read_m)
			load_w <= rd_word;
	end

	// loaded word or alu result
	assign wb_data = mem_to_reg_w ? load_w : alu_w;

endmodule

// ==== mips_top.sv ====
`timescale 1ns/1ps

module mips_top import mips_ctrl_pkg::*; #(
	parameter int len_addr      = 8,
	parameter int len_dmem_addr = 6
) (
	input  logic                clk,
	input  logic                arst_n,
	// program load
	input  logic                debug_flag,
	input  logic [len_addr-1:0] in_addr_mem_inst,
	input  logic [data_w-1:0]   in_ins_to_mem,
	input  logic                wea_ram_inst,
	// register peek
	input  logic [reg_w-1:0]    dbg_reg_addr,
	output logic [data_w-1:0]   dbg_reg_data,
	output logic [7:0]          out_pc,
	output logic                halt_flag
);

	////////////////////////////////////////
	// stage interconnect
	////////////////////////////////////////

	// if -> id
	logic [data_w-1:0] pc_plus4_d;
	logic [data_w-1:0] instruction_d;
	logic              halt_d;
	// id -> if
	logic              stall;
	logic              jump;
	logic [data_w-1:0] jump_target;
	// id -> ex
	logic [data_w-1:0] pc_plus4_e;
	logic [data_w-1:0] reg1_e;
	logic [data_w-1:0] reg2_e;
	logic [data_w-1:0] imm_e;
	logic [reg_w-1:0]  rs_e;
	logic [reg_w-1:0]  rt_e;
	logic [reg_w-1:0]  rd_e;
	logic              reg_write_e;
	logic              mem_to_reg_e;
	logic              mem_read_e;
	logic              mem_write_e;
	logic              branch_e;
	logic              alu_src_imm_e;
	logic              reg_dst_rd_e;
	alu_op_t           alu_op_e;
	logic              halt_e;
	// ex -> mem
	logic [data_w-1:0] alu_m;
	logic [data_w-1:0] store_data_m;
	logic [reg_w-1:0]  write_reg_m;
	logic [data_w-1:0] branch_target_m;
	logic              zero_m;
	logic              mem_read_m;
	logic              mem_write_m;
	logic              branch_m;
	logic              reg_write_m;
	logic              mem_to_reg_m;
	logic              halt_m;
	// mem/wb back to the front
	logic              pc_src;
	logic [data_w-1:0] branch_target;
	logic              wb_reg_write;
	logic [reg_w-1:0]  wb_reg;
	logic [data_w-1:0] wb_data;

	if_id #(
		.len_addr(len_addr)
	) u_if_id (
		.clk(clk),
		.arst_n(arst_n),
		.debug_flag(debug_flag),
		.in_addr_mem_inst(in_addr_mem_inst),
		.in_ins_to_mem(in_ins_to_mem),
		.wea_ram_inst(wea_ram_inst),
		.stall(stall),
		.jump(jump),
		.jump_target(jump_target),
		.pc_src(pc_src),
		.branch_target(branch_target),
		.pc_plus4_d(pc_plus4_d),
		.instruction_d(instruction_d),
		.halt_d(halt_d),
		.out_pc(out_pc)
	);

	// pc_src doubles as the flush
	id_ex u_id_ex (
		.clk(clk),
		.arst_n(arst_n),
		.debug_flag(debug_flag),
		.pc_plus4_d(pc_plus4_d),
		.instruction_d(instruction_d),
		.halt_d(halt_d),
		.flush(pc_src),
		.wb_reg_write(wb_reg_write),
		.wb_reg(wb_reg),
		.wb_data(wb_data),
		.dbg_reg_addr(dbg_reg_addr),
		.dbg_reg_data(dbg_reg_data),
		.stall(stall),
		.jump(jump),
		.jump_target(jump_target),
		.pc_plus4_e(pc_plus4_e),
		.reg1_e(reg1_e),
		.reg2_e(reg2_e),
		.imm_e(imm_e),
		.rs_e(rs_e),
		.rt_e(rt_e),
		.rd_e(rd_e),
		.reg_write_e(reg_write_e),
		.mem_to_reg_e(mem_to_reg_e),
		.mem_read_e(mem_read_e),
		.mem_write_e(mem_write_e),
		.branch_e(branch_e),
		.alu_src_imm_e(alu_src_imm_e),
		.reg_dst_rd_e(reg_dst_rd_e),
		.alu_op_e(alu_op_e),
		.halt_e(halt_e)
	);

	ex_mem u_ex_mem (
		.clk(clk),
		.arst_n(arst_n),
		.debug_flag(debug_flag),
		.flush(pc_src),
		.pc_plus4_e(pc_plus4_e),
		.reg1_e(reg1_e),
		.reg2_e(reg2_e),
		.imm_e(imm_e),
		.rs_e(rs_e),
		.rt_e(rt_e),
		.rd_e(rd_e),
		.reg_write_e(reg_write_e),
		.mem_to_reg_e(mem_to_reg_e),
		.mem_read_e(mem_read_e),
		.mem_write_e(mem_write_e),
		.branch_e(branch_e),
		.alu_src_imm_e(alu_src_imm_e),
		.reg_dst_rd_e(reg_dst_rd_e),
		.alu_op_e(alu_op_e),
		.halt_e(halt_e),
		.wb_reg_write(wb_reg_write),
		.wb_reg(wb_reg),
		.wb_data(wb_data),
		.alu_m(alu_m),
		.store_data_m(store_data_m),
		.write_reg_m(write_reg_m),
		.branch_target_m(branch_target_m),
		.zero_m(zero_m),
		.mem_read_m(mem_read_m),
		.mem_write_m(mem_write_m),
		.branch_m(branch_m),
		.reg_write_m(reg_write_m),
		.mem_to_reg_m(mem_to_reg_m),
		.halt_m(halt_m)
	);

	mem_wb #(
		.len_dmem_addr(len_dmem_addr)
	) u_mem_wb (
		.clk(clk),
		.arst_n(arst_n),
		.debug_flag(debug_flag),
		.alu_m(alu_m),
		.store_data_m(store_data_m),
		.write_reg_m(write_reg_m),
		.branch_target_m(branch_target_m),
		.zero_m(zero_m),
		.mem_read_m(mem_read_m),
		.mem_write_m(mem_write_m),
		.branch_m(branch_m),
		.reg_write_m(reg_write_m),
		.mem_to_reg_m(mem_to_reg_m),
		.halt_m(halt_m),
		.pc_src(pc_src),
		.branch_target(branch_target),
		.wb_reg_write(wb_reg_write),
		.wb_reg(wb_reg),
		.wb_data(wb_data),
		.halt_w(halt_flag)
	);

endmodule

// ==== tb_mips_top.sv ====
`timescale 1ns/1ps

module tb_mips_top import mips_isa_pkg::*; ();

	localparam int n_rows          = 4;
	localparam int max_words       = 16;
	localparam int max_checks      = 4;
	localparam int reset_cycles    = 10;
	// each program loads, runs and reads back well inside 200 cycles
	localparam int watchdog_cycles = n_rows * 200 + reset_cycles;

	logic        clk;
	logic        arst_n;
	logic        debug_flag;
	logic [7:0]  in_addr_mem_inst;
	logic [31:0] in_ins_to_mem;
	logic        wea_ram_inst;
	logic [4:0]  dbg_reg_addr;
	logic [31:0] dbg_reg_data;
	logic [7:0]  out_pc;
	logic        halt_flag;

	// program table, one row per program
	logic [31:0] prog [n_rows][max_words];
	int          prog_len [n_rows];
	// register number and expected value per row
	logic [4:0]  chk_reg [n_rows][max_checks];
	logic [31:0] chk_val [n_rows][max_checks];

	logic [15:0] lfsr_state;
	int          check_count;
	int          err_count;

	mips_top #(
		.len_addr(8),
		.len_dmem_addr(6)
	) u_mips_top (
		.clk(clk),
		.arst_n(arst_n),
		.debug_flag(debug_flag),
		.in_addr_mem_inst(in_addr_mem_inst),
		.in_ins_to_mem(in_ins_to_mem),
		.wea_ram_inst(wea_ram_inst),
		.dbg_reg_addr(dbg_reg_addr),
		.dbg_reg_data(dbg_reg_data),
		.out_pc(out_pc),
		.halt_flag(halt_flag)
	);

	// 8 ns period
	always #4 clk = ~clk;

	////////////////////////////////////////
	// assembler and random source
	////////////////////////////////////////

	function automatic logic [31:0] enc_r(input funct_t fn, input logic [4:0] rd,
			input logic [4:0] rs, input logic [4:0] rt);
		return {op_rtype, rs, rt, rd, 5'd0, fn};
	endfunction

	// addi, lw, sw, beq
	function automatic logic [31:0] enc_i(input opcode_t op, input logic [4:0] rt,
			input logic [4:0] rs, input logic [15:0] imm);
		return {op, rs, rt, imm};
	endfunction

	// target is a word address
	function automatic logic [31:0] enc_j(input logic [25:0] target);
		return {op_j, target};
	endfunction

	function automatic logic [31:0] enc_halt();
		return {op_halt, 26'd0};
	endfunction

	function automatic logic [31:0] sext16(input logic [15:0] v);
		return {{16{v[15]}}, v};
	endfunction

	// x^16 + x^14 + x^13 + x^11 + 1
	function automatic logic [15:0] lfsr_next(input logic [15:0] s);
		return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
	endfunction

	// one lfsr step per bit
	task automatic draw_bits(input int n, output logic [15:0] v);
		v = '0;
		for (int i = 0; i < n; i++) begin
			lfsr_state = lfsr_next(lfsr_state);
			v = {v[14:0], lfsr_state[0]};
		end
	endtask

	////////////////////////////////////////
	// table construction
	////////////////////////////////////////

	task automatic put_word(input int row, input logic [31:0] word);
		prog[row][prog_len[row]] = word;
		prog_len[row] = prog_len[row] + 1;
	endtask

	task automatic put_check(input int row, input int slot, input logic [4:0] r,
			input logic [31:0] v);
		chk_reg[row][slot] = r;
		chk_val[row][slot] = v;
	endtask

	task automatic build_table();
		logic [15:0] imm_a;
		logic [15:0] imm_b;
		logic [15:0] slot;
		logic [15:0] off;
		logic [31:0] a;
		logic [31:0] b;
		logic [31:0] sum;
		logic [31:0] diff;
		logic [31:0] slt_res;
		for (int r = 0; r < n_rows; r++) begin
			prog_len[r] = 0;
			// unused slots are no-ops
			for (int i = 0; i < max_words; i++)
				prog[r][i] = '0;
		end

		// arithmetic chain, forwarding from both stages and decode bypass
		draw_bits(16, imm_a);
		draw_bits(16, imm_b);
		a       = sext16(imm_a);
		b       = sext16(imm_b);
		sum     = a + b;
		diff    = a - sum;
		slt_res = ($signed(diff) < $signed(b)) ? 32'd1 : 32'd0;
		put_word(0, enc_i(op_addi, 5'd1, 5'd0, imm_a));
		put_word(0, enc_i(op_addi, 5'd2, 5'd0, imm_b));
		put_word(0, enc_r(fn_add, 5'd3, 5'd1, 5'd2));
		put_word(0, enc_r(fn_sub, 5'd4, 5'd1, 5'd3));
		put_word(0, enc_r(fn_and, 5'd5, 5'd4, 5'd3));
		put_word(0, enc_r(fn_or, 5'd6, 5'd5, 5'd1));
		put_word(0, enc_r(fn_slt, 5'd7, 5'd4, 5'd2));
		put_word(0, enc_halt());
		put_check(0, 0, 5'd3, sum);
		put_check(0, 1, 5'd4, diff);
		put_check(0, 2, 5'd6, (diff & sum) | a);
		put_check(0, 3, 5'd7, slt_res);

		// store, load, dependent add right behind the load
		draw_bits(16, imm_a);
		draw_bits(16, imm_b);
		draw_bits(6, slot);
		a   = sext16(imm_a);
		b   = sext16(imm_b);
		off = {8'h00, slot[5:0], 2'b00};
		put_word(1, enc_i(op_addi, 5'd8, 5'd0, imm_a));
		put_word(1, enc_i(op_addi, 5'd9, 5'd0, imm_b));
		put_word(1, enc_i(op_sw, 5'd8, 5'd0, off));
		put_word(1, enc_i(op_lw, 5'd10, 5'd0, off));
		put_word(1, enc_r(fn_add, 5'd11, 5'd10, 5'd9));
		put_word(1, enc_halt());
		put_check(1, 0, 5'd8, a);
		put_check(1, 1, 5'd9, b);
		put_check(1, 2, 5'd10, a);
		put_check(1, 3, 5'd11, a + b);

		// taken beq over three words, then a beq that falls through
		put_word(2, enc_i(op_addi, 5'd1, 5'd0, 16'd7));
		put_word(2, enc_i(op_addi, 5'd2, 5'd0, 16'd7));
		put_word(2, enc_i(op_addi, 5'd3, 5'd0, 16'd1));
		put_word(2, enc_i(op_addi, 5'd4, 5'd0, 16'd2));
		put_word(2, enc_i(op_beq, 5'd2, 5'd1, 16'd3));
		put_word(2, enc_i(op_addi, 5'd3, 5'd0, 16'd100));
		put_word(2, enc_i(op_addi, 5'd4, 5'd0, 16'd100));
		// r1 = r3 here would make the next beq skip the r6 write
		put_word(2, enc_i(op_addi, 5'd1, 5'd0, 16'd1));
		put_word(2, enc_i(op_beq, 5'd3, 5'd1, 16'd1));
		put_word(2, enc_i(op_addi, 5'd6, 5'd0, 16'd55));
		put_word(2, enc_i(op_addi, 5'd7, 5'd6, 16'd1));
		put_word(2, enc_halt());
		put_check(2, 0, 5'd3, 32'd1);
		put_check(2, 1, 5'd4, 32'd2);
		put_check(2, 2, 5'd6, 32'd55);
		put_check(2, 3, 5'd7, 32'd56);

		// $0 target, then j over the slot and one more word
		put_word(3, enc_i(op_addi, 5'd0, 5'd0, 16'd99));
		put_word(3, enc_i(op_addi, 5'd15, 5'd0, 16'd5));
		put_word(3, enc_i(op_addi, 5'd13, 5'd0, 16'd3));
		put_word(3, enc_j(26'd6));
		put_word(3, enc_i(op_addi, 5'd13, 5'd0, 16'd77));
		put_word(3, enc_i(op_addi, 5'd14, 5'd0, 16'd77));
		put_word(3, enc_i(op_addi, 5'd14, 5'd13, 16'd10));
		put_word(3, enc_halt());
		put_check(3, 0, 5'd0, 32'd0);
		put_check(3, 1, 5'd15, 32'd5);
		put_check(3, 2, 5'd13, 32'd3);
		put_check(3, 3, 5'd14, 32'd13);
	endtask

	////////////////////////////////////////
	// checks
	////////////////////////////////////////

	task automatic check_word(input logic [31:0] got, input logic [31:0] exp,
			input string name);
		check_count++;
		if (got !== exp) begin
			err_count++;
			$display("error at time %0t: %s is 0x%08h, expected 0x%08h", $time, name, got, exp);
		end
	endtask

	task automatic check_flag(input logic got, input logic exp, input string name);
		check_count++;
		if (got !== exp) begin
			err_count++;
			$display("error at time %0t: %s is %b, expected %b", $time, name, got, exp);
		end
	endtask

	// load, run to halt, watch the pc, read back registers
	task automatic run_row(input int row);
		logic [7:0] halt_pc;
		// halt is the last word, fetch parks on it
		halt_pc = 8'((prog_len[row] - 1) * 4);
		@(posedge clk);
		debug_flag <= 1'b1;
		for (int i = 0; i < max_words; i++) begin
			@(posedge clk);
			wea_ram_inst     <= 1'b1;
			in_addr_mem_inst <= 8'(i);
			in_ins_to_mem    <= prog[row][i];
		end
		@(posedge clk);
		wea_ram_inst <= 1'b0;
		@(negedge clk);
		check_flag(halt_flag, 1'b0, "halt_flag");
		@(posedge clk);
		debug_flag <= 1'b0;
		do
			@(negedge clk);
		while (halt_flag !== 1'b1);
		repeat (10) begin
			@(negedge clk);
			check_word({24'h0, out_pc}, {24'h0, halt_pc}, "out_pc");
			check_flag(halt_flag, 1'b1, "halt_flag");
		end
		for (int k = 0; k < max_checks; k++) begin
			@(posedge clk);
			dbg_reg_addr <= chk_reg[row][k];
			@(negedge clk);
			check_word(dbg_reg_data, chk_val[row][k],
				$sformatf("dbg_reg_data r%0d", chk_reg[row][k]));
		end
	endtask

	////////////////////////////////////////
	// main sequence
	////////////////////////////////////////

	initial begin
		clk              = 1'b0;
		arst_n           = 1'b0;
		// held in load mode until the first program is in
		debug_flag       = 1'b1;
		in_addr_mem_inst = '0;
		in_ins_to_mem    = '0;
		wea_ram_inst     = 1'b0;
		dbg_reg_addr     = '0;
		lfsr_state       = 16'd6;
		check_count      = 0;
		err_count        = 0;
		build_table();
		repeat (reset_cycles) @(posedge clk);
		arst_n <= 1'b1;
		@(negedge clk);
		check_flag(halt_flag, 1'b0, "halt_flag");
		check_word({24'h0, out_pc}, 32'h0, "out_pc");
		for (int row = 0; row < n_rows; row++)
			run_row(row);
		$display("%0d checks, %0d errors", check_count, err_count);
		if (err_count == 0)
			$display("All tests passed!");
		else
			$display("Test failures found");
		$finish;
	end

	// stuck pipeline or a halt that never arrives
	initial begin
		repeat (watchdog_cycles) @(posedge clk);
		$display("watchdog expired after %0d cycles, halt_flag never came up", watchdog_cycles);
		$display("Test failures found");
		$finish;
	end

endmodule

// ==== flist.f ====
mips_isa_pkg.sv
mips_ctrl_pkg.sv
if_id.sv
id_ex.sv
ex_mem.sv
mem_wb.sv
mips_top.sv
tb_mips_top.sv

// ==== run.sh ====
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --top-module tb_mips_top -f flist.f -o sim_mips
./obj_dir/sim_mips | tee sim.log

if grep -q 'All tests passed!' sim.log; then
	echo "simulation passed"
else
	echo "simulation failed"
	exit 1
fi
